// ==== bench/instr_mem_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

// handshake checks, bound into prog_ram for the write port and fetch_resp_mux for fetches
// each bind ties off the port it cannot see
module instr_mem_asserts (
   input logic                clk_i,
   input logic                rst_n_i,
   input logic                fetch_req_i,
   input logic                rvalid_i,
   input logic                wr_req_i,
   input logic                ack_i,
   input imem_pkg::wr_state_e wr_state_i
);

   // rvalid exactly one cycle after each accepted fetch, and never otherwise
   rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      fetch_req_i |=> rvalid_i) else $error("rvalid missing one cycle after fetch req");
   rvalid_only_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !fetch_req_i |=> !rvalid_i) else $error("rvalid without a fetch req");

   // ack rises only the cycle after req is seen without ack
   ack_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(ack_i) |-> $past(wr_req_i) && !$past(ack_i)) else $error("ack rose without req");
   ack_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wr_req_i && !ack_i) |=> ack_i) else $error("ack late after req");

   // four-phase order
   ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(ack_i) |-> !$past(wr_req_i)) else $error("ack fell while req high");
   ack_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (ack_i && wr_req_i) |=> ack_i) else $error("ack dropped while req held");
   req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(wr_req_i) |-> !ack_i) else $error("req rose before ack dropped");

   // acked phase ends on the first edge that sees req low
   ack_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wr_state_i == imem_pkg::wr_acked && !wr_req_i) |=> !ack_i)
      else $error("ack still high a cycle after req dropped");

   // both outputs clear one cycle into reset
   reset_clears: assert property (@(posedge clk_i)
      !rst_n_i |=> !rvalid_i && !ack_i) else $error("rvalid or ack high after reset");

endmodule

bind prog_ram instr_mem_asserts u_wr_asserts (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .fetch_req_i (1'b0),                            // fetch side checked in the mux
   .rvalid_i    (1'b0),
   .wr_req_i    (wr_i.req),
   .ack_i       (ack_o),
   .wr_state_i  (state_q)
);

bind fetch_resp_mux instr_mem_asserts u_fetch_asserts (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .fetch_req_i (req_i),
   .rvalid_i    (rsp_o.rvalid),
   .wr_req_i    (1'b0),                            // write side checked in prog_ram
   .ack_i       (1'b0),
   .wr_state_i  (imem_pkg::wr_idle)
);

`default_nettype wire

// ==== bench/instr_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// trace driven testbench for the instruction memory
// every cycle goes through next_cycle, which samples the fetch response on the falling edge
module instr_mem_tb;

   localparam int max_wait = 20;                   // cycles before a handshake counts as stalled

   logic                  clk;
   logic                  rst_n;
   imem_pkg::fetch_req_t  fetch;                   // core side fetch request
   imem_pkg::fetch_rsp_t  rsp;
   imem_pkg::ram_wr_t     wr;                      // loader side write request
   logic                  wr_ack;

   // trace operations, loaded up front so a write can see the fetch paired with it
   byte                          op_kind [$];
   logic [31:0]                  op_addr [$];
   logic [31:0]                  op_data [$];

   // fetches in flight, oldest first
   logic [imem_pkg::data_w-1:0]  exp_q      [$];
   logic [imem_pkg::addr_w-1:0]  exp_addr_q [$];

   int errors;
   int checks;
   bit stalled;                                    // handshake timeout or unusable trace

   instr_mem u_dut (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .fetch_i     (fetch),
      .fetch_rsp_o (rsp),
      .wr_i        (wr),
      .wr_ack_o    (wr_ack)
   );

   always #4 clk = ~clk;                           // 8 ns period

   // one falling edge, then compare any response against the oldest fetch
   task automatic next_cycle();
      logic [imem_pkg::data_w-1:0] exp;
      logic [imem_pkg::addr_w-1:0] a;
      @(negedge clk);
      checks++;
      assert (rsp.gnt === 1'b1) else begin        // fetch port never stalls
         errors++;
         $display("[ERROR] t=%0t: gnt=%b, expected gnt high on every cycle", $time, rsp.gnt);
      end
      if (rsp.rvalid) begin
         checks++;
         assert (exp_q.size() != 0) else begin
            errors++;
            $display("[ERROR] t=%0t: rvalid high with no fetch outstanding", $time);
         end
         if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            a   = exp_addr_q.pop_front();
            assert (rsp.rdata === exp) else begin
               errors++;
               $display("[ERROR] t=%0t: fetch 0x%04h returned 0x%08h, expected 0x%08h",
                        $time, a, rsp.rdata, exp);
            end
         end
      end
   endtask

   // puts a fetch on the port, it is accepted on the next rising edge
   task automatic issue_fetch(input logic [31:0] addr, input logic [31:0] expected);
      fetch.req  = 1'b1;
      fetch.addr = addr[imem_pkg::addr_w-1:0];
      exp_q.push_back(expected);
      exp_addr_q.push_back(addr[imem_pkg::addr_w-1:0]);
   endtask

   // ends a fetch burst and waits until every response came back
   task automatic drain_fetches();
      int cycles;
      cycles = 0;
      if (fetch.req) begin
         next_cycle();                             // last fetch of the burst gets its edge
         fetch.req = 1'b0;
      end
      while (exp_q.size() != 0 && cycles < max_wait) begin
         next_cycle();
         cycles++;
      end
      if (exp_q.size() != 0) begin
         stalled = 1'b1;
         $display("timeout: fetch port gave no rvalid for %0d outstanding fetches",
                  exp_q.size());
      end
   endtask

   // one four-phase write, optionally with a fetch on the same edge
   task automatic do_write(input logic [31:0] word_addr, input logic [31:0] data,
                           input bit with_fetch, input logic [31:0] f_addr,
                           input logic [31:0] f_exp);
      int cycles;
      int hold;
      wr.req  = 1'b1;
      wr.addr = word_addr[$clog2(imem_pkg::ram_words)-1:0];
      wr.data = data;
      if (with_fetch) begin
         issue_fetch(f_addr, f_exp);               // same edge as the write
      end
      next_cycle();
      fetch.req = 1'b0;
      cycles    = 1;
      while (wr_ack !== 1'b1 && cycles < max_wait) begin
         next_cycle();
         cycles++;
      end
      if (wr_ack !== 1'b1) begin
         stalled = 1'b1;
         $display("timeout: write to word 0x%03h never got ack", wr.addr);
      end else begin
         assert (cycles == 1) else begin
            errors++;
            $display("[ERROR] t=%0t: ack rose after %0d cycles, expected 1", $time, cycles);
         end
         hold = 1 + int'($urandom % 2);            // loader keeps req up past the ack
         repeat (hold) begin
            next_cycle();
            checks++;
            assert (wr_ack === 1'b1) else begin    // a drop here would allow a second write
               errors++;
               $display("[ERROR] t=%0t: ack dropped while req was still held", $time);
            end
         end
         wr.req = 1'b0;
         next_cycle();
         cycles = 1;
         while (wr_ack !== 1'b0 && cycles < max_wait) begin
            next_cycle();
            cycles++;
         end
         if (wr_ack !== 1'b0) begin
            stalled = 1'b1;
            $display("timeout: ack for word 0x%03h stayed high after req dropped", wr.addr);
         end else begin
            assert (cycles == 1) else begin
               errors++;
               $display("[ERROR] t=%0t: ack fell after %0d cycles, expected 1", $time, cycles);
            end
         end
      end
   endtask

   initial begin
      int          fd;
      int          n;
      int          i;
      string       line;
      byte         kind;
      logic [31:0] a;
      logic [31:0] d;

      clk     = 1'b0;
      rst_n   = 1'b0;
      fetch   = '0;
      wr      = '0;
      errors  = 0;
      checks  = 0;
      stalled = 1'b0;
      void'($urandom(61120));                      // single seed for the whole run

      // trace lines are kind, address, data, '#' lines are comments
      fd = $fopen("bench/instr_mem_trace.txt", "r");
      if (fd == 0) begin
         stalled = 1'b1;
         $display("could not open the trace file bench/instr_mem_trace.txt");
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
               n = $sscanf(line, "%c %h %h", kind, a, d);
               if (n == 3) begin
                  op_kind.push_back(kind);
                  op_addr.push_back(a);
                  op_data.push_back(d);
               end
            end
         end
         $fclose(fd);
         if (op_kind.size() == 0) begin
            stalled = 1'b1;
            $display("the trace file holds no operations");
         end
      end

      repeat (2) @(negedge clk);                   // reset for two cycles
      rst_n = 1'b1;
      next_cycle();
      checks++;
      assert (rsp.rvalid === 1'b0 && wr_ack === 1'b0) else begin
         errors++;
         $display("[ERROR] t=%0t: rvalid=%b ack=%b after reset, expected both low",
                  $time, rsp.rvalid, wr_ack);
      end

      i = 0;
      while (i < op_kind.size() && !stalled) begin
         case (op_kind[i])
            "B": begin
               next_cycle();                       // previous fetch takes its edge
               issue_fetch(op_addr[i], op_data[i]);
            end
            "F", "W": begin
               drain_fetches();
               repeat (int'($urandom % 4)) next_cycle(); // idle gap
               if (op_kind[i] == "F") begin
                  issue_fetch(op_addr[i], op_data[i]);
               end else if (i + 1 < op_kind.size() && op_kind[i+1] == "B") begin
                  do_write(op_addr[i], op_data[i], 1'b1, op_addr[i+1], op_data[i+1]);
                  i++;                             // fetch consumed with the write
               end else begin
                  do_write(op_addr[i], op_data[i], 1'b0, 32'h0, 32'h0);
               end
            end
            default: begin
               stalled = 1'b1;
               $display("unknown operation '%c' in trace line %0d", op_kind[i], i);
            end
         endcase
         i++;
      end
      if (!stalled) begin
         drain_fetches();
      end

      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0 && !stalled) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/instr_mem_trace.txt ====
# columns: kind addr data, hex. F and B take a byte address and the expected word,
# W takes a ram word address and the word written. B follows the line before at once.
# boot image words
F 0000 00000093
B 0004 00000113
B 0024 000022b7
B 003c ffdff06f
# past the end of the image
F 0040 00000013
F 01fc 00000013
# aliases through bits 12:9, low bits ignored
F 1e24 000022b7
F 1a08 00000193
F 0027 000022b7
# ram fill and read back
W 000 deadbeef
F 2000 deadbeef
F 2003 deadbeef
W 7ff 12345678
F 3ffe 12345678
# rom and ram alternating back to back
F 0000 00000093
B 2000 deadbeef
B 0004 00000113
B 3ffc 12345678
B 0040 00000013
B 2001 deadbeef
# fetch on the write edge sees the old word
W 010 11111111
F 2040 11111111
W 010 cafef00d
B 2040 11111111
F 2040 cafef00d
# second write leaves the first word alone
W 020 aaaa5555
W 021 5555aaaa
F 2080 aaaa5555
F 2084 5555aaaa

// ==== include/boot_rom_image.svh ====
`ifndef BOOT_ROM_IMAGE_SVH
`define BOOT_ROM_IMAGE_SVH

// boot image, included inside boot_rom
// clears a few registers, sets up sp and jumps to the start of program ram

localparam int boot_image_len = 16;           // words actually in the image

localparam logic [imem_pkg::data_w-1:0] boot_image [boot_image_len] = '{
   32'h0000_0093,                             // addi x1, x0, 0
   32'h0000_0113,                             // addi x2, x0, 0
   32'h0000_0193,                             // addi x3, x0, 0
   32'h0000_0213,                             // addi x4, x0, 0
   32'h0000_0293,                             // addi x5, x0, 0
   32'h0000_0313,                             // addi x6, x0, 0
   32'h0000_0393,                             // addi x7, x0, 0
   32'h0000_0413,                             // addi x8, x0, 0
   32'h0000_4137,                             // lui sp, 0x4 puts the stack top at 0x4000
   32'h0000_22b7,                             // lui t0, 0x2 loads the program ram base
   32'h0002_8067,                             // jalr x0, 0(t0)
   32'h0000_006f,                             // jal x0, 0 parks here if the jump returns
   32'h0010_0073,                             // ebreak
   32'h3020_0073,                             // mret
   32'h1050_0073,                             // wfi
   32'hffdf_f06f                              // jal x0, -4 loops back to wfi
};

`endif

// ==== rtl/boot_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

// boot rom with a registered read word
// only byte address bits 8:2 decode, so bits 12:9 alias onto the same 128 words
module boot_rom (
   input  logic                          clk_i,
   input  imem_pkg::fetch_req_t          fetch_i,   // shared fetch request
   output logic [imem_pkg::data_w-1:0]   rdata_o    // word of the last accepted fetch
);

`include "boot_rom_image.svh"

   logic [$clog2(imem_pkg::rom_words)-1:0] word_idx;   // 7 bit word index
   logic                                   in_image;   // index falls inside the table
   logic [imem_pkg::data_w-1:0]            rom_word;   // combinational lookup result

   // word index from bits 8:2, byte offset dropped
   assign word_idx = fetch_i.addr[$clog2(imem_pkg::rom_words)+1:2];

   // the image is shorter than the rom, the rest reads as nop
   assign in_image = (int'(word_idx) < boot_image_len);

   always_comb begin
      rom_word = imem_pkg::nop_word;                      // default for the empty tail
      if (in_image) begin
         rom_word = boot_image[word_idx[$clog2(boot_image_len)-1:0]];
      end
   end

   // read register, loads only on an accepted fetch
   // holds the previous word otherwise so the mux sees a stable value
   always_ff @(posedge clk_i) begin
      if (fetch_i.req) begin
         rdata_o <= rom_word;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/fetch_resp_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

// forms the fetch response from the two registered read words
// region and valid are registered alongside the memories so the response
// always lines up with the fetch that caused it, even back to back
module fetch_resp_mux (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic                          req_i,       // fetch req, accepted every high edge
   input  imem_pkg::region_e             region_i,    // decoded region of this fetch
   input  logic [imem_pkg::data_w-1:0]   rom_data_i,  // registered boot rom word
   input  logic [imem_pkg::data_w-1:0]   ram_data_i,  // registered program ram word
   output imem_pkg::fetch_rsp_t          rsp_o        // response to the core
);

   logic              valid_q;    // req delayed by one cycle
   imem_pkg::region_e region_q;   // region of the fetch now on the outputs

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_q  <= 1'b0;
         region_q <= imem_pkg::region_rom;
      end else begin
         valid_q <= req_i;                        // rvalid exactly one cycle later
         if (req_i) begin
            region_q <= region_i;                 // same edge the memories load
         end
      end
   end

   assign rsp_o.gnt    = 1'b1;                    // no stalls on the fetch port
   assign rsp_o.rvalid = valid_q;

   // pick the side the registered region names, no extra latency here
   always_comb begin
      if (region_q == imem_pkg::region_ram) begin
         rsp_o.rdata = ram_data_i;
      end else begin
         rsp_o.rdata = rom_data_i;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/imem_pkg.sv ====
`default_nettype none

// shared address map, enums and port structs of the instruction memory
package imem_pkg;

   // address map
   localparam int addr_w      = 14;           // fetch byte address width
   localparam int data_w      = 32;           // one instruction word
   localparam int rom_words   = 128;          // boot rom depth
   localparam int ram_words   = 2048;         // program ram depth
   localparam int ram_sel_bit = 13;           // byte address bit picking rom or ram

   // returned for rom indexes past the end of the boot image
   localparam logic [data_w-1:0] nop_word = 32'h0000_0013; // addi x0, x0, 0

   // which memory a fetch goes to
   typedef enum logic {
      region_rom = 1'b0,                      // bit 13 low
      region_ram = 1'b1                       // bit 13 high
   } region_e;

   // four-phase write handshake on the loader port
   typedef enum logic {
      wr_idle  = 1'b0,                        // waiting for req
      wr_acked = 1'b1                         // word written, ack held until req drops
   } wr_state_e;

   // fetch request from the core
   typedef struct packed {
      logic              req;                 // accepted on every edge where high
      logic [addr_w-1:0] addr;                // byte address, bits 1:0 ignored
   } fetch_req_t;

   // fetch response back to the core
   typedef struct packed {
      logic              gnt;                 // always granted
      logic              rvalid;              // one cycle after req
      logic [data_w-1:0] rdata;               // word paired with rvalid
   } fetch_rsp_t;

   // loader write port, whole words only
   typedef struct packed {
      logic                         req;      // held high until ack
      logic [$clog2(ram_words)-1:0] addr;     // word address into the ram
      logic [data_w-1:0]            data;     // stable while req is high
   } ram_wr_t;

endpackage

`default_nettype wire

// ==== rtl/instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// instruction memory top
// byte address bit 13 splits the map, low half boot rom and high half program ram
module instr_mem (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  imem_pkg::fetch_req_t   fetch_i,       // core fetch request
   output imem_pkg::fetch_rsp_t   fetch_rsp_o,   // core fetch response
   input  imem_pkg::ram_wr_t      wr_i,          // loader write port
   output logic                   wr_ack_o       // four-phase ack
);

   imem_pkg::region_e           fetch_region;   // decoded from ram_sel_bit
   logic [imem_pkg::data_w-1:0] rom_rdata;      // boot rom read register
   logic [imem_pkg::data_w-1:0] ram_rdata;      // program ram read register

   assign fetch_region = fetch_i.addr[imem_pkg::ram_sel_bit] ? imem_pkg::region_ram
                                                             : imem_pkg::region_rom;

   // both memories read every accepted fetch, the mux picks one a cycle later
   boot_rom u_boot_rom (
      .clk_i   (clk_i),
      .fetch_i (fetch_i),
      .rdata_o (rom_rdata)
   );

   prog_ram u_prog_ram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .fetch_i (fetch_i),
      .wr_i    (wr_i),
      .ack_o   (wr_ack_o),
      .rdata_o (ram_rdata)
   );

   fetch_resp_mux u_resp_mux (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .req_i      (fetch_i.req),
      .region_i   (fetch_region),
      .rom_data_i (rom_rdata),
      .ram_data_i (ram_rdata),
      .rsp_o      (fetch_rsp_o)
   );

endmodule

`default_nettype wire

// ==== rtl/prog_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// program ram, one registered fetch read port and one loader write port
// the write port runs a four-phase req/ack handshake, one write per handshake
module prog_ram (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  imem_pkg::fetch_req_t          fetch_i,   // shared fetch request
   input  imem_pkg::ram_wr_t             wr_i,      // loader write request
   output logic                          ack_o,     // handshake ack back to the loader
   output logic [imem_pkg::data_w-1:0]   rdata_o    // word of the last accepted fetch
);

   logic [imem_pkg::data_w-1:0]            mem [imem_pkg::ram_words]; // word array, no reset
   logic [$clog2(imem_pkg::ram_words)-1:0] rd_idx;    // fetch word index, bits 12:2
   imem_pkg::wr_state_e                    state_q;   // handshake state
   imem_pkg::wr_state_e                    state_d;
   logic                                   wr_en;     // single cycle write strobe

   assign rd_idx = fetch_i.addr[imem_pkg::ram_sel_bit-1:2];

   // handshake fsm
   // idle plus req writes once and moves to acked
   // acked waits for req low before going back
   always_comb begin
      state_d = state_q;
      wr_en   = 1'b0;
      case (state_q)
         imem_pkg::wr_idle: begin
            if (wr_i.req) begin
               wr_en   = 1'b1;                   // word goes in on this edge
               state_d = imem_pkg::wr_acked;     // ack rises on the same edge
            end
         end
         imem_pkg::wr_acked: begin
            if (!wr_i.req) begin
               state_d = imem_pkg::wr_idle;      // loader released, drop ack
            end
         end
         default: state_d = imem_pkg::wr_idle;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= imem_pkg::wr_idle;
      end else begin
         state_q <= state_d;
      end
   end

   assign ack_o = (state_q == imem_pkg::wr_acked); // high for the whole acked phase

   // array write, a fetch of the same word on this edge still reads the old data
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // registered read, loads on accepted fetches only
   always_ff @(posedge clk_i) begin
      if (fetch_i.req) begin
         rdata_o <= mem[rd_idx];
      end
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module instr_mem_tb -f vlog.f -o instr_mem_sim \
   > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/instr_mem_sim > sim.log 2>&1
cat sim.log

grep -qx "TESTS PASSED" sim.log && echo "run passed" || { echo "run failed, see sim.log"; exit 1; }

// ==== vlog.f ====
+incdir+include
rtl/imem_pkg.sv
rtl/boot_rom.sv
rtl/prog_ram.sv
rtl/fetch_resp_mux.sv
rtl/instr_mem.sv
bench/instr_mem_asserts.sv
bench/instr_mem_tb.sv
